// File: logic/dbg_ring_pkg.sv
/*
 * debug ring package
 * flit widths, node id type, output buffer sizing and the
 * header/payload view of one DII flit word
 */

package dbg_ring_pkg;

  localparam int dii_width = 16;                       // flit data width

  localparam int buf_depth = 4;                        // ring output FIFO entries
  localparam int buf_ptr_width = $clog2(buf_depth);    // read/write pointer bits
  localparam int buf_cnt_width = $clog2(buf_depth + 1); // occupancy counter bits

  // node id as carried in the first flit of a worm
  typedef logic [dii_width-1:0] dii_id_t;

  // one flit word, decoded as header on the first flit of a worm
  // and as raw payload on every following flit
  typedef union packed {
    dii_id_t              dest;     // destination node id, first flit only
    logic [dii_width-1:0] payload;  // raw body word
  } dii_word_u;

endpackage

// File: logic/dii_if.sv
/*
 * DII flit link
 * data, last marker and valid/ready handshake between two blocks
 */

`timescale 1ns/1ps

interface dii_if;

  dbg_ring_pkg::dii_word_u data;  // flit word, header or payload view
  logic                    last;  // high on the final flit of a worm
  logic                    valid; // sender has a flit
  logic                    ready; // receiver takes the flit

  // flit producer side
  modport tx (
    output data,
    output last,
    output valid,
    input  ready
  );

  // flit consumer side
  modport rx (
    input  data,
    input  last,
    input  valid,
    output ready
  );

endinterface

// File: logic/ring_router_demux.sv
/*
 * ring router demux
 * splits incoming ring worms by destination id, worms for this
 * node go to the local port, all others pass on along the ring
 */

`timescale 1ns/1ps

module ring_router_demux (
  input  logic                  clk,
  input  logic                  rst,
  input  dbg_ring_pkg::dii_id_t id,        // this node's id
  dii_if.rx                     ring_rx,   // flits arriving from the ring
  dii_if.tx                     local_out, // worms addressed to this node
  dii_if.tx                     pass       // worms for other nodes
);

  logic worm;        // a worm is in progress, header already taken
  logic worm_local;  // route of the worm in progress
  logic is_local;    // header of the current flit matches id
  logic sel_local;   // route used for the current flit
  logic accept;      // flit transfer on the ring input

  // only meaningful on a header flit, masked by worm below
  assign is_local = (ring_rx.data.dest == id);

  // header flits route on the fly, body flits follow the latched route
  assign sel_local = worm ? worm_local : is_local;

  // data and last fan out unchanged, only valid is steered
  assign local_out.data = ring_rx.data;
  assign local_out.last = ring_rx.last;
  assign pass.data      = ring_rx.data;
  assign pass.last      = ring_rx.last;

  assign local_out.valid = ring_rx.valid & sel_local;
  assign pass.valid      = ring_rx.valid & ~sel_local;

  // back-pressure only from the output the worm is heading to
  assign ring_rx.ready = sel_local ? local_out.ready : pass.ready;

  assign accept = ring_rx.valid & ring_rx.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      worm       <= 1'b0;
      worm_local <= 1'b0;
    end else if (accept) begin
      if (ring_rx.last) begin
        worm <= 1'b0;                   // worm done, next flit is a header
      end else if (!worm) begin
        worm       <= 1'b1;             // header accepted, lock the route
        worm_local <= is_local;
      end
    end
  end

endmodule

// File: logic/ring_router_mux.sv
/*
 * ring router mux
 * merges pass-through ring worms and locally injected worms onto one
 * stream, ring side wins at worm boundaries, a lock keeps worms whole
 */

`timescale 1ns/1ps

module ring_router_mux (
  input  logic clk,
  input  logic rst,
  dii_if.rx    ring_side,   // pass-through worms from the demux
  dii_if.rx    local_side,  // worms injected by the local port
  dii_if.tx    merged       // towards the output buffer
);

  logic locked;      // a worm is in flight on merged
  logic lock_local;  // owner of the worm in flight
  logic sel_local;   // local side currently selected
  logic accept;      // flit transfer on merged

  // idle: ring has priority, local gets the slot when ring is quiet
  always_comb begin
    if (locked) begin
      sel_local = lock_local;
    end else begin
      sel_local = ~ring_side.valid;
    end
  end

  // combinational forward path of the selected side
  always_comb begin
    if (sel_local) begin
      merged.data  = local_side.data;
      merged.last  = local_side.last;
      merged.valid = local_side.valid;
    end else begin
      merged.data  = ring_side.data;
      merged.last  = ring_side.last;
      merged.valid = ring_side.valid;
    end
  end

  // the side not selected sees ready low
  assign ring_side.ready  = merged.ready & ~sel_local;
  assign local_side.ready = merged.ready & sel_local;

  assign accept = merged.valid & merged.ready;

  // lock taken on the accepted first flit, released on the accepted
  // last flit, single-flit worms never lock
  always_ff @(posedge clk) begin
    if (rst) begin
      locked     <= 1'b0;
      lock_local <= 1'b0;
    end else if (accept) begin
      if (merged.last) begin
        locked <= 1'b0;                 // worm complete, rearbitrate
      end else if (!locked) begin
        locked     <= 1'b1;             // first flit gone, hold winner
        lock_local <= sel_local;
      end
    end
  end

endmodule

// File: logic/dii_buffer.sv
/*
 * DII flit buffer
 * small circular FIFO decoupling the ring output from the merge stage
 */

`timescale 1ns/1ps

module dii_buffer (
  input  logic clk,
  input  logic rst,
  dii_if.rx    wr,  // flits in
  dii_if.tx    rd   // flits out, head of the queue
);

  localparam logic [dbg_ring_pkg::buf_ptr_width-1:0] ptr_last =
    dbg_ring_pkg::buf_ptr_width'(dbg_ring_pkg::buf_depth - 1);
  localparam logic [dbg_ring_pkg::buf_cnt_width-1:0] cnt_full =
    dbg_ring_pkg::buf_cnt_width'(dbg_ring_pkg::buf_depth);

  dbg_ring_pkg::dii_word_u mem_data [dbg_ring_pkg::buf_depth]; // flit words
  logic                    mem_last [dbg_ring_pkg::buf_depth]; // last markers

  logic [dbg_ring_pkg::buf_ptr_width-1:0] wr_ptr;  // next free slot
  logic [dbg_ring_pkg::buf_ptr_width-1:0] rd_ptr;  // head slot
  logic [dbg_ring_pkg::buf_cnt_width-1:0] count;   // flits held

  logic do_wr;  // flit written this cycle
  logic do_rd;  // flit read this cycle

  assign wr.ready = (count != cnt_full);   // room for one more
  assign rd.valid = (count != '0);         // head is valid when not empty
  assign rd.data  = mem_data[rd_ptr];
  assign rd.last  = mem_last[rd_ptr];

  assign do_wr = wr.valid & wr.ready;
  assign do_rd = rd.valid & rd.ready;

  // storage, no reset on payload
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem_data[wr_ptr] <= wr.data;
      mem_last[wr_ptr] <= wr.last;
    end
  end

  // pointers wrap at buf_depth, not only at powers of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;  // write only
        2'b01:   count <= count - 1'b1;  // read only
        default: count <= count;         // none, or both at once
      endcase
    end
  end

endmodule

// File: logic/ring_router.sv
/*
 * debug ring router node
 * splits ring worms for this node to the local port, merges the rest
 * with local injection and buffers the result onto the ring output
 */

`timescale 1ns/1ps

module ring_router (
  input  logic                               clk,
  input  logic                               rst,
  input  dbg_ring_pkg::dii_id_t              id,

  input  logic [dbg_ring_pkg::dii_width-1:0] ring_in_data,
  input  logic                               ring_in_last,
  input  logic                               ring_in_valid,
  output logic                               ring_in_ready,

  output logic [dbg_ring_pkg::dii_width-1:0] ring_out_data,
  output logic                               ring_out_last,
  output logic                               ring_out_valid,
  input  logic                               ring_out_ready,

  input  logic [dbg_ring_pkg::dii_width-1:0] local_in_data,
  input  logic                               local_in_last,
  input  logic                               local_in_valid,
  output logic                               local_in_ready,

  output logic [dbg_ring_pkg::dii_width-1:0] local_out_data,
  output logic                               local_out_last,
  output logic                               local_out_valid,
  input  logic                               local_out_ready
);

  dii_if ring_rx ();    // ring input
  dii_if local_out ();  // demux to local port
  dii_if pass ();       // demux to mux, ring side
  dii_if local_in ();   // local port to mux
  dii_if merged ();     // mux to buffer
  dii_if ring_out ();   // buffer to ring output

  // ring input ports into the link
  assign ring_rx.data  = ring_in_data;
  assign ring_rx.last  = ring_in_last;
  assign ring_rx.valid = ring_in_valid;
  assign ring_in_ready = ring_rx.ready;

  // local injection ports into the link
  assign local_in.data  = local_in_data;
  assign local_in.last  = local_in_last;
  assign local_in.valid = local_in_valid;
  assign local_in_ready = local_in.ready;

  // local delivery link out to ports
  assign local_out_data  = local_out.data;
  assign local_out_last  = local_out.last;
  assign local_out_valid = local_out.valid;
  assign local_out.ready = local_out_ready;

  // buffered ring link out to ports
  assign ring_out_data  = ring_out.data;
  assign ring_out_last  = ring_out.last;
  assign ring_out_valid = ring_out.valid;
  assign ring_out.ready = ring_out_ready;

  ring_router_demux demux_i (
    .clk       (clk),
    .rst       (rst),
    .id        (id),
    .ring_rx   (ring_rx),
    .local_out (local_out),
    .pass      (pass)
  );

  ring_router_mux mux_i (
    .clk        (clk),
    .rst        (rst),
    .ring_side  (pass),
    .local_side (local_in),
    .merged     (merged)
  );

  dii_buffer buffer_i (
    .clk (clk),
    .rst (rst),
    .wr  (merged),
    .rd  (ring_out)
  );

endmodule

// File: tb/ring_router_model.svh
/*
 * ring router testbench model
 * LFSR random source, packet generator and expected flit queues
 */

`ifndef RING_ROUTER_MODEL_SVH
`define RING_ROUTER_MODEL_SVH

localparam dbg_ring_pkg::dii_id_t node_id = 16'h0025;  // bit 15 clear like all ring words
localparam int ring_packets  = 40;                       // packets arriving on ring_in
localparam int local_packets = 30;                       // packets injected on local_in

logic [15:0] lfsr_state;     // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1

logic [16:0] ring_flits[$];  // {last, data} to drive on ring_in
logic [16:0] local_flits[$]; // {last, data} to drive on local_in
logic [16:0] local_q[$];     // expected on local_out
logic [16:0] pass_q[$];      // expected ring pass-through on ring_out
logic [16:0] inj_q[$];       // expected injected worms on ring_out

// one LFSR step, the new bit is the random bit
function automatic logic lfsr_step();
  logic fb;
  fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
  lfsr_state = {lfsr_state[14:0], fb};
  return fb;
endfunction

// n random bits, one step per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_step()};
  end
  return v;
endfunction

// bit 15 of every word tags the source, 0 ring side, 1 local side
task automatic make_packet(input logic from_local);
  dbg_ring_pkg::dii_word_u w;
  logic [31:0]             r;
  logic [16:0]             f;
  logic                    here;  // ring packet addressed to this node
  int                      len;
  len  = 1 + int'(rand_bits(3) % 6);                  // 1 to 6 flits
  here = from_local ? 1'b0 : (rand_bits(1) != 0);
  r    = rand_bits(15);
  w.dest = here ? node_id : {from_local, r[14:0]};
  if (!from_local && !here && w.dest == node_id) begin
    w.dest = w.dest ^ 16'h0001;                        // keep foreign dest off our id
  end
  for (int i = 0; i < len; i++) begin
    if (i > 0) begin
      r = rand_bits(15);
      w.payload = {from_local, r[14:0]};
    end
    f = {(i == len - 1), w};
    if (from_local) begin
      local_flits.push_back(f);
      inj_q.push_back(f);
    end else begin
      ring_flits.push_back(f);
      if (here) local_q.push_back(f);
      else pass_q.push_back(f);
    end
  end
endtask

`endif

// File: tb/ring_router_tb.sv
/*
 * ring router testbench
 * random ring and local worms under random output back-pressure,
 * both output ports checked flit by flit against expected queues
 */

`timescale 1ns/1ps

module ring_router_tb;

  logic                               clk;
  logic                               rst;
  logic [dbg_ring_pkg::dii_width-1:0] ring_in_data;
  logic                               ring_in_last;
  logic                               ring_in_valid;
  logic                               ring_in_ready;
  logic [dbg_ring_pkg::dii_width-1:0] ring_out_data;
  logic                               ring_out_last;
  logic                               ring_out_valid;
  logic                               ring_out_ready;
  logic [dbg_ring_pkg::dii_width-1:0] local_in_data;
  logic                               local_in_last;
  logic                               local_in_valid;
  logic                               local_in_ready;
  logic [dbg_ring_pkg::dii_width-1:0] local_out_data;
  logic                               local_out_last;
  logic                               local_out_valid;
  logic                               local_out_ready;

  `include "ring_router_model.svh"

  int   rst_cycles = 0;   // falling edges seen in reset
  int   cycles = 0;       // rising edges since start
  int   limit = 0;        // timeout in cycles
  int   checks = 0;
  int   ring_idx = 0;     // next ring_in flit
  int   local_idx = 0;    // next local_in flit
  logic ring_acc = 1'b0;  // ring_in transfer at last rising edge
  logic local_acc = 1'b0;
  logic rst_d = 1'b1;     // rst at previous rising edge
  logic worm_open = 1'b0; // ring_out worm in progress
  logic worm_src = 1'b0;  // its source, 1 for local
  int   gen_local, gen_pass, gen_inj;
  int   rx_local = 0;
  int   rx_pass = 0;
  int   rx_inj = 0;
  int   err_reset = 0;
  int   err_routing = 0;
  int   err_pass = 0;
  int   err_inject = 0;
  int   err_bp = 0;
  int   failing = 0;      // tests with errors
  int   errs;

  ring_router ring_router_i (
    .clk             (clk),
    .rst             (rst),
    .id              (node_id),
    .ring_in_data    (ring_in_data),
    .ring_in_last    (ring_in_last),
    .ring_in_valid   (ring_in_valid),
    .ring_in_ready   (ring_in_ready),
    .ring_out_data   (ring_out_data),
    .ring_out_last   (ring_out_last),
    .ring_out_valid  (ring_out_valid),
    .ring_out_ready  (ring_out_ready),
    .local_in_data   (local_in_data),
    .local_in_last   (local_in_last),
    .local_in_valid  (local_in_valid),
    .local_in_ready  (local_in_ready),
    .local_out_data  (local_out_data),
    .local_out_last  (local_out_last),
    .local_out_valid (local_out_valid),
    .local_out_ready (local_out_ready)
  );

  always #20 clk = ~clk;  // 40 ns period

  task automatic check_word(input string test, input logic [16:0] exp, input logic [16:0] act,
                            inout int err);
    checks++;
    assert (act === exp) else begin
      $display("[FAIL] %s expected %h actual %h", test, exp, act);
      err++;
    end
  endtask

  task automatic check_count(input string test, input int exp, input int act, inout int err);
    checks++;
    assert (act == exp) else begin
      $display("[FAIL] %s expected %0d actual %0d", test, exp, act);
      err++;
    end
  endtask

  // a flit arriving with nothing left to expect is a duplicate or a misroute
  task automatic check_pending(input string test, input string port, input int n,
                               inout int err);
    checks++;
    assert (n != 0) else begin
      $display("%s: a flit arrived on %s while no flit was expected there", test, port);
      err++;
    end
  endtask

  task automatic report_test(input string name, input int err);
    if (err == 0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, err);
    if (err != 0) failing++;
  endtask

  // hold while stalled, else advance and roll a new gap
  task automatic next_flit(input logic acc, input int total, inout int idx, inout logic valid);
    if (acc) idx++;
    if (!valid || acc) valid = (idx < total) && (rand_bits(2) != 0);
  endtask

  task automatic take_local();
    logic [16:0] got;
    got = {local_out_last, local_out_data};
    rx_local++;                              // every accepted flit, expected or not
    check_pending("routing", "local_out", local_q.size(), err_routing);
    if (local_q.size() != 0) begin
      check_word("routing", local_q.pop_front(), got, err_routing);
    end
  endtask

  task automatic take_ring();
    logic [16:0] got;
    logic        src;
    got = {ring_out_last, ring_out_data};
    src = worm_open ? worm_src : ring_out_data[15];  // worm owner fixed by its first flit
    check_word("injection source", {16'd0, src}, {16'd0, ring_out_data[15]}, err_inject);
    if (src) begin
      rx_inj++;
      check_pending("injection", "ring_out", inj_q.size(), err_inject);
      if (inj_q.size() != 0) begin
        check_word("injection", inj_q.pop_front(), got, err_inject);
      end
    end else begin
      rx_pass++;
      check_pending("pass_through", "ring_out", pass_q.size(), err_pass);
      if (pass_q.size() != 0) begin
        check_word("pass_through", pass_q.pop_front(), got, err_pass);
      end
    end
    worm_open = !ring_out_last;
    worm_src  = src;
  endtask

  function automatic logic drained();
    return ring_idx >= ring_flits.size() && local_idx >= local_flits.size() &&
           local_q.size() == 0 && pass_q.size() == 0 && inj_q.size() == 0;
  endfunction

  // stimulus, reset release and output ready, all on the falling edge
  always @(negedge clk) begin
    if (rst_cycles < 16) rst_cycles++;
    rst             = (rst_cycles < 16);
    ring_out_ready  = (rand_bits(2) != 0);  // ready about 3 cycles in 4
    local_out_ready = (rand_bits(2) != 0);
    if (!rst) begin
      next_flit(ring_acc, ring_flits.size(), ring_idx, ring_in_valid);
      next_flit(local_acc, local_flits.size(), local_idx, local_in_valid);
    end
    if (ring_idx < ring_flits.size()) {ring_in_last, ring_in_data} = ring_flits[ring_idx];
    if (local_idx < local_flits.size()) {local_in_last, local_in_data} = local_flits[local_idx];
  end

  // handshake capture and output monitors
  always @(posedge clk) begin
    cycles++;
    ring_acc  = ring_in_valid && ring_in_ready;
    local_acc = local_in_valid && local_in_ready;
    if (cycles > 1 && (rst || rst_d)) begin  // first edge has not reset anything yet
      check_word("reset", 17'd0, {15'd0, ring_out_valid, local_out_valid}, err_reset);
    end
    if (rst_d && !rst) report_test("reset", err_reset);
    rst_d = rst;
    if (!rst && local_out_valid && local_out_ready) take_local();
    if (!rst && ring_out_valid && ring_out_ready) take_ring();
  end

  initial begin
    clk             = 1'b0;
    rst             = 1'b1;
    ring_in_data    = '0;
    ring_in_last    = 1'b0;
    ring_in_valid   = 1'b0;
    local_in_data   = '0;
    local_in_last   = 1'b0;
    local_in_valid  = 1'b0;
    ring_out_ready  = 1'b0;
    local_out_ready = 1'b0;
    lfsr_state      = 16'd52497;
    for (int p = 0; p < ring_packets; p++) make_packet(1'b0);
    for (int p = 0; p < local_packets; p++) make_packet(1'b1);
    gen_local = local_q.size();
    gen_pass  = pass_q.size();
    gen_inj   = inj_q.size();
    limit = (ring_flits.size() + local_flits.size()) * 40 + 200 + dbg_ring_pkg::buf_depth;
    while (!drained()) @(posedge clk);
    repeat (4 * dbg_ring_pkg::buf_depth) @(posedge clk);  // room for stray extra flits
    report_test("routing", err_routing);
    report_test("pass_through", err_pass);
    report_test("injection", err_inject);
    check_count("back_pressure local count", gen_local, rx_local, err_bp);
    check_count("back_pressure pass count", gen_pass, rx_pass, err_bp);
    check_count("back_pressure injected count", gen_inj, rx_inj, err_bp);
    report_test("back_pressure", err_bp);
    report_test("liveness", 0);
    errs = err_reset + err_routing + err_pass + err_inject + err_bp;
    $display("summary: 6 tests, %0d with errors, %0d checks, %0d errors", failing, checks, errs);
    if (errs == 0 && failing == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // liveness guard
  initial begin
    wait (limit > 0);
    while (cycles < limit) @(posedge clk);
    $display("timeout: traffic still pending after %0d cycles", cycles);
    report_test("liveness", 1);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: flist.f
+incdir+tb
logic/dbg_ring_pkg.sv
logic/dii_if.sv
logic/ring_router_demux.sv
logic/ring_router_mux.sv
logic/dii_buffer.sv
logic/ring_router.sv
tb/ring_router_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ring router testbench with Verilator
# the verdict comes from the pass message in the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
  -f flist.f \
  --top-module ring_router_tb \
  -Mdir obj_dir \
  -o ring_router_sim > "$log" 2>&1 \
  && ./obj_dir/ring_router_sim >> "$log" 2>&1 \
  || { echo "build or simulation error, see $log"; exit 1; }

grep -q "ALL CHECKS PASSED" "$log" \
  && { echo "simulation ok, see $log"; exit 0; } \
  || { echo "simulation reported errors, see $log"; exit 1; }
